//--- hw/backend_pkg.sv
package backend_pkg;

    // slots retired per cycle
    localparam int ISSUE_WIDTH = 2;

    localparam int GPR_ADDR_W = 5;
    localparam int DATA_W     = 32;

    // small CSR table, fixed addresses 0x0 to 0x7
    localparam int CSR_ADDR_W = 14;
    localparam int CSR_COUNT  = 8;

    // result of one slot as it leaves the memory stage
    typedef struct packed {
        logic                  reg_write_en;
        logic [GPR_ADDR_W-1:0] reg_write_addr;
        logic [DATA_W-1:0]     reg_write_data;
        logic                  csr_write_en;
        logic [CSR_ADDR_W-1:0] csr_write_addr;
        logic [DATA_W-1:0]     csr_write_data;
    } mem_wb_t;

    // commit record per slot
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] pc;
    } commit_ctrl_t;

    // register push-forward toward dispatch and the register file
    typedef struct packed {
        logic                  reg_write_en;
        logic [GPR_ADDR_W-1:0] reg_write_addr;
        logic [DATA_W-1:0]     reg_write_data;
    } reg_pf_t;

    // single CSR push-forward, one write per cycle at most
    typedef struct packed {
        logic                  csr_write_en;
        logic [CSR_ADDR_W-1:0] csr_write_addr;
        logic [DATA_W-1:0]     csr_write_data;
    } csr_pf_t;

endpackage

//--- hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic clk,
    input  logic rst_n_i,

    // pipeline control
    input  logic flush_i,
    input  logic pause_i,
    input  logic pause_mem_i,

    // from memory stage
    input  backend_pkg::mem_wb_t      [backend_pkg::ISSUE_WIDTH-1:0] wb_i,
    input  backend_pkg::commit_ctrl_t [backend_pkg::ISSUE_WIDTH-1:0] commit_ctrl_i,

    // registered records
    output backend_pkg::mem_wb_t      [backend_pkg::ISSUE_WIDTH-1:0] wb_o,
    output backend_pkg::commit_ctrl_t [backend_pkg::ISSUE_WIDTH-1:0] commit_o,
    output logic                                                     commit_new_o,

    // push-forward
    output backend_pkg::reg_pf_t      [backend_pkg::ISSUE_WIDTH-1:0] reg_pf_o,
    output backend_pkg::csr_pf_t                                     csr_pf_o
);
    import backend_pkg::*;

    // clear beats hold, hold beats load
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || pause_mem_i) begin
            wb_o         <= '0;
            commit_o     <= '0;
            commit_new_o <= 1'b0;
        end else if (pause_i) begin
            // records stay, but nothing new to retire
            commit_new_o <= 1'b0;
        end else begin
            wb_o         <= wb_i;
            commit_o     <= commit_ctrl_i;
            commit_new_o <= 1'b1;
        end
    end

    // one register push-forward per slot
    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_reg_pf
        assign reg_pf_o[s].reg_write_en   = wb_o[s].reg_write_en;
        assign reg_pf_o[s].reg_write_addr = wb_o[s].reg_write_addr;
        assign reg_pf_o[s].reg_write_data = wb_o[s].reg_write_data;
    end

    // lowest slot with a CSR write gets the port
    always_comb begin
        csr_pf_o = '0;
        for (int s = ISSUE_WIDTH - 1; s >= 0; s--) begin
            if (wb_o[s].csr_write_en) begin
                csr_pf_o.csr_write_en   = 1'b1;
                csr_pf_o.csr_write_addr = wb_o[s].csr_write_addr;
                csr_pf_o.csr_write_data = wb_o[s].csr_write_data;
            end
        end
    end

endmodule

//--- hw/gpr_file.sv
`timescale 1ns/1ps

module gpr_file #(
    parameter int NUM_READ_PORTS = 4
) (
    input  logic clk,
    input  logic rst_n_i,

    // write ports, one per slot
    input  backend_pkg::reg_pf_t [backend_pkg::ISSUE_WIDTH-1:0] wr_pf_i,

    // read ports
    input  logic [NUM_READ_PORTS-1:0][backend_pkg::GPR_ADDR_W-1:0] rd_addr_i,
    output logic [NUM_READ_PORTS-1:0][backend_pkg::DATA_W-1:0]     rd_data_o
);
    import backend_pkg::*;

    localparam int NUM_REGS = 2 ** GPR_ADDR_W;

    // register 0 has no storage
    logic [DATA_W-1:0] regs [NUM_REGS-1:1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later slot is younger, its write lands last
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (wr_pf_i[s].reg_write_en && wr_pf_i[s].reg_write_addr != '0) begin
                    regs[wr_pf_i[s].reg_write_addr] <= wr_pf_i[s].reg_write_data;
                end
            end
        end
    end

    // combinational reads
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0;
            end else begin
                rd_data_o[p] = regs[rd_addr_i[p]];
            end
        end
    end

endmodule

//--- hw/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic clk,
    input  logic rst_n_i,

    // write from the writeback stage
    input  backend_pkg::csr_pf_t wr_pf_i,

    // read port
    input  logic [backend_pkg::CSR_ADDR_W-1:0] rd_addr_i,
    output logic [backend_pkg::DATA_W-1:0]     rd_data_o
);
    import backend_pkg::*;

    localparam int IDX_W = $clog2(CSR_COUNT);

    logic [DATA_W-1:0] csr_q [CSR_COUNT];

    logic             wr_hit;
    logic             rd_hit;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             bypass;

    // implemented entries sit at 0x0 .. CSR_COUNT-1
    assign wr_idx = wr_pf_i.csr_write_addr[IDX_W-1:0];
    assign rd_idx = rd_addr_i[IDX_W-1:0];
    assign wr_hit = wr_pf_i.csr_write_en &&
                    (wr_pf_i.csr_write_addr[CSR_ADDR_W-1:IDX_W] == '0);
    assign rd_hit = (rd_addr_i[CSR_ADDR_W-1:IDX_W] == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < CSR_COUNT; i++) begin
                csr_q[i] <= '0;
            end
        end else if (wr_hit) begin
            csr_q[wr_idx] <= wr_pf_i.csr_write_data;
        end
    end

    // write in flight to the same entry wins
    assign bypass = wr_hit && (wr_idx == rd_idx);

    always_comb begin
        if (!rd_hit) begin
            rd_data_o = '0;
        end else if (bypass) begin
            rd_data_o = wr_pf_i.csr_write_data;
        end else begin
            rd_data_o = csr_q[rd_idx];
        end
    end

endmodule

//--- hw/commit_tracker.sv
`timescale 1ns/1ps

module commit_tracker (
    input  logic clk,
    input  logic rst_n_i,

    input  backend_pkg::commit_ctrl_t [backend_pkg::ISSUE_WIDTH-1:0] commit_i,
    input  logic                                                     commit_new_i,

    output logic [63:0]                      retired_o,
    output logic [backend_pkg::DATA_W-1:0]   last_pc_o
);
    import backend_pkg::*;

    localparam int CNT_W = $clog2(ISSUE_WIDTH + 1);

    logic [CNT_W-1:0]  valid_cnt;
    logic [DATA_W-1:0] young_pc;

    // count valid slots, youngest valid pc wins
    always_comb begin
        valid_cnt = '0;
        young_pc  = last_pc_o;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (commit_i[s].valid) begin
                valid_cnt = valid_cnt + 1'b1;
                young_pc  = commit_i[s].pc;
            end
        end
    end

    // held records are not counted again
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retired_o <= '0;
            last_pc_o <= '0;
        end else if (commit_new_i) begin
            retired_o <= retired_o + 64'(valid_cnt);
            last_pc_o <= young_pc;
        end
    end

endmodule

//--- hw/operand_forward.sv
`timescale 1ns/1ps

module operand_forward #(
    parameter int NUM_READ_PORTS = 4
) (
    input  logic [NUM_READ_PORTS-1:0][backend_pkg::GPR_ADDR_W-1:0] rd_addr_i,
    input  backend_pkg::reg_pf_t [backend_pkg::ISSUE_WIDTH-1:0]   reg_pf_i,
    input  logic [NUM_READ_PORTS-1:0][backend_pkg::DATA_W-1:0]     file_data_i,
    output logic [NUM_READ_PORTS-1:0][backend_pkg::DATA_W-1:0]     rd_data_o
);
    import backend_pkg::*;

    // file is written one cycle late, so the stage contents take priority
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            rd_data_o[p] = file_data_i[p];
            // ascending scan, younger slot overrides
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (reg_pf_i[s].reg_write_en &&
                    reg_pf_i[s].reg_write_addr == rd_addr_i[p]) begin
                    rd_data_o[p] = reg_pf_i[s].reg_write_data;
                end
            end
            // x0 stays zero even if a slot targets it
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0;
            end
        end
    end

endmodule

//--- hw/wb_backend_top.sv
`timescale 1ns/1ps

module wb_backend_top #(
    parameter int NUM_READ_PORTS = 4
) (
    input  logic clk,
    input  logic rst_n_i,

    // from memory stage
    input  backend_pkg::mem_wb_t      [backend_pkg::ISSUE_WIDTH-1:0] wb_i,
    input  backend_pkg::commit_ctrl_t [backend_pkg::ISSUE_WIDTH-1:0] commit_ctrl_i,

    // from pipeline control
    input  logic flush_i,
    input  logic pause_i,
    input  logic pause_mem_i,

    // operand reads from dispatch
    input  logic [NUM_READ_PORTS-1:0][backend_pkg::GPR_ADDR_W-1:0] rd_addr_i,
    output logic [NUM_READ_PORTS-1:0][backend_pkg::DATA_W-1:0]     rd_data_o,

    // csr read
    input  logic [backend_pkg::CSR_ADDR_W-1:0] csr_rd_addr_i,
    output logic [backend_pkg::DATA_W-1:0]     csr_rd_data_o,

    // commit status
    output logic [63:0]                                              retired_o,
    output logic [backend_pkg::DATA_W-1:0]                           last_pc_o,
    output backend_pkg::commit_ctrl_t [backend_pkg::ISSUE_WIDTH-1:0] commit_o
);
    import backend_pkg::*;

    logic                      commit_new;
    reg_pf_t [ISSUE_WIDTH-1:0] reg_pf;
    csr_pf_t                   csr_pf;

    logic [NUM_READ_PORTS-1:0][DATA_W-1:0] file_data;

    wb_stage i_wb_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .pause_i       (pause_i),
        .pause_mem_i   (pause_mem_i),
        .wb_i          (wb_i),
        .commit_ctrl_i (commit_ctrl_i),
        .wb_o          (),
        .commit_o      (commit_o),
        .commit_new_o  (commit_new),
        .reg_pf_o      (reg_pf),
        .csr_pf_o      (csr_pf)
    );

    gpr_file #(
        .NUM_READ_PORTS (NUM_READ_PORTS)
    ) i_gpr_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_pf_i   (reg_pf),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (file_data)
    );

    csr_file i_csr_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_pf_i   (csr_pf),
        .rd_addr_i (csr_rd_addr_i),
        .rd_data_o (csr_rd_data_o)
    );

    commit_tracker i_commit_tracker (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .commit_i     (commit_o),
        .commit_new_i (commit_new),
        .retired_o    (retired_o),
        .last_pc_o    (last_pc_o)
    );

    operand_forward #(
        .NUM_READ_PORTS (NUM_READ_PORTS)
    ) i_operand_forward (
        .rd_addr_i   (rd_addr_i),
        .reg_pf_i    (reg_pf),
        .file_data_i (file_data),
        .rd_data_o   (rd_data_o)
    );

endmodule

//--- tests/wb_backend_props.sv
`timescale 1ns/1ps

module wb_backend_props #(
    parameter int NUM_READ_PORTS = 4
) (
    input logic clk,
    input logic rst_n_i,
    input logic flush_i,
    input backend_pkg::reg_pf_t [backend_pkg::ISSUE_WIDTH-1:0]     reg_pf_i,
    input logic [NUM_READ_PORTS-1:0][backend_pkg::GPR_ADDR_W-1:0] rd_addr_i,
    input logic [NUM_READ_PORTS-1:0][backend_pkg::DATA_W-1:0]     rd_data_i,
    input logic [63:0]                                            retired_i
);
    import backend_pkg::*;

    // read by the testbench summary
    int unsigned fail_count = 0;
    logic        any_reg_en;

    always_comb begin
        any_reg_en = 1'b0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            any_reg_en = any_reg_en | reg_pf_i[s].reg_write_en;
        end
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !any_reg_en) else begin
        $error("register write enable set in the cycle after a flush");
        fail_count++;
    end

    for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_x0
        a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
            rd_addr_i[p] == '0 |-> rd_data_i[p] == '0) else begin
            $error("register 0 read back nonzero on port %0d", p);
            fail_count++;
        end
    end

    a_retired_mono: assert property (@(posedge clk) disable iff (!rst_n_i)
        retired_i >= $past(retired_i)) else begin
        $error("retired count went down");
        fail_count++;
    end

endmodule

bind wb_backend_top wb_backend_props #(
    .NUM_READ_PORTS (NUM_READ_PORTS)
) i_props (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .reg_pf_i  (reg_pf),
    .rd_addr_i (rd_addr_i),
    .rd_data_i (rd_data_o),
    .retired_i (retired_o)
);

//--- tests/tb_wb_backend.sv
`timescale 1ns/1ps

module tb_wb_backend;
    import backend_pkg::*;

    localparam int NUM_READ_PORTS = 4;
    // tests take about 150 cycles
    localparam int MAX_CYCLES = 400;

    logic                                      clk;
    logic                                      rst_n_i;
    mem_wb_t      [ISSUE_WIDTH-1:0]            wb_i;
    commit_ctrl_t [ISSUE_WIDTH-1:0]            commit_ctrl_i;
    logic                                      flush_i;
    logic                                      pause_i;
    logic                                      pause_mem_i;
    logic [NUM_READ_PORTS-1:0][GPR_ADDR_W-1:0] rd_addr_i;
    logic [NUM_READ_PORTS-1:0][DATA_W-1:0]     rd_data_o;
    logic [CSR_ADDR_W-1:0]                     csr_rd_addr_i;
    logic [DATA_W-1:0]                         csr_rd_data_o;
    logic [63:0]                               retired_o;
    logic [DATA_W-1:0]                         last_pc_o;
    commit_ctrl_t [ISSUE_WIDTH-1:0]            commit_o;

    // reference state
    logic [DATA_W-1:0] model_regs [32];
    logic [DATA_W-1:0] model_csr [CSR_COUNT];
    logic [63:0]       model_retired;
    logic [DATA_W-1:0] model_last_pc;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;

    wb_backend_top #(
        .NUM_READ_PORTS (NUM_READ_PORTS)
    ) i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wb_i          (wb_i),
        .commit_ctrl_i (commit_ctrl_i),
        .flush_i       (flush_i),
        .pause_i       (pause_i),
        .pause_mem_i   (pause_mem_i),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .csr_rd_addr_i (csr_rd_addr_i),
        .csr_rd_data_o (csr_rd_data_o),
        .retired_o     (retired_o),
        .last_pc_o     (last_pc_o),
        .commit_o      (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped, no end after %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    function automatic mem_wb_t reg_rec(input logic [GPR_ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] data);
        mem_wb_t r;
        r = '0;
        r.reg_write_en   = 1'b1;
        r.reg_write_addr = addr;
        r.reg_write_data = data;
        return r;
    endfunction

    function automatic mem_wb_t csr_rec(input logic [CSR_ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] data);
        mem_wb_t r;
        r = '0;
        r.csr_write_en   = 1'b1;
        r.csr_write_addr = addr;
        r.csr_write_data = data;
        return r;
    endfunction

    // slot 1 is younger; only the first CSR request in slot order lands
    function automatic void apply_model(input mem_wb_t [ISSUE_WIDTH-1:0] w,
                                        input commit_ctrl_t [ISSUE_WIDTH-1:0] c);
        logic csr_taken;
        csr_taken = 1'b0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (w[s].reg_write_en && w[s].reg_write_addr != 0) begin
                model_regs[w[s].reg_write_addr] = w[s].reg_write_data;
            end
            if (w[s].csr_write_en && !csr_taken) begin
                csr_taken = 1'b1;
                if (w[s].csr_write_addr < CSR_COUNT) begin
                    model_csr[w[s].csr_write_addr] = w[s].csr_write_data;
                end
            end
            if (c[s].valid) begin
                model_retired++;
                model_last_pc = c[s].pc;
            end
        end
    endfunction

    task automatic drive_slots(input mem_wb_t [ISSUE_WIDTH-1:0] w,
                               input commit_ctrl_t [ISSUE_WIDTH-1:0] c);
        @(posedge clk);
        wb_i          <= w;
        commit_ctrl_i <= c;
    endtask

    task automatic commit_slots(input mem_wb_t [ISSUE_WIDTH-1:0] w,
                                input commit_ctrl_t [ISSUE_WIDTH-1:0] c);
        drive_slots(w, c);
        apply_model(w, c);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        wb_i          <= '0;
        commit_ctrl_i <= '0;
    endtask

    task automatic read_all_regs(input string name);
        for (int base = 0; base < 32; base += NUM_READ_PORTS) begin
            @(posedge clk);
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                rd_addr_i[p] <= GPR_ADDR_W'((base + p) % 32);
            end
            @(negedge clk);
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                check_value(name, model_regs[(base + p) % 32], rd_data_o[p]);
            end
        end
    endtask

    task automatic check_csr(input string name, input logic [CSR_ADDR_W-1:0] addr);
        @(posedge clk);
        csr_rd_addr_i <= addr;
        @(negedge clk);
        check_value(name, (addr < CSR_COUNT) ? model_csr[addr] : '0, csr_rd_data_o);
    endtask

    task automatic test_basic_commit();
        mem_wb_t      [ISSUE_WIDTH-1:0] w;
        commit_ctrl_t [ISSUE_WIDTH-1:0] c;
        c = '0;
        for (int i = 0; i < 20; i++) begin
            w[0] = reg_rec(GPR_ADDR_W'($urandom_range(31, 1)), $urandom);
            w[1] = reg_rec(GPR_ADDR_W'($urandom_range(31, 1)), $urandom);
            // same target now and then, last cycle included
            if (i % 4 == 3) begin
                w[1].reg_write_addr = w[0].reg_write_addr;
            end
            commit_slots(w, c);
        end
        idle_cycle();
        idle_cycle();
        read_all_regs("basic_commit");
    endtask

    task automatic test_forwarding();
        mem_wb_t      [ISSUE_WIDTH-1:0] w;
        commit_ctrl_t [ISSUE_WIDTH-1:0] c;
        logic [DATA_W-1:0]              old_val;
        c = '0;
        w[0] = reg_rec(5'd7, ~model_regs[7]);
        w[1] = reg_rec(5'd9, ~model_regs[9]);
        commit_slots(w, c);
        rd_addr_i[0] <= 5'd7;
        rd_addr_i[1] <= 5'd9;
        rd_addr_i[2] <= 5'd0;
        idle_cycle();
        // record sits in wb_q, file not yet written
        @(negedge clk);
        check_value("forward_slot0", model_regs[7], rd_data_o[0]);
        check_value("forward_slot1", model_regs[9], rd_data_o[1]);
        check_value("forward_x0", '0, rd_data_o[2]);
        old_val = model_regs[12];
        w[0] = reg_rec(5'd12, ~old_val);
        w[1] = reg_rec(5'd12, old_val ^ 32'h0000_ffff);
        commit_slots(w, c);
        rd_addr_i[0] <= 5'd12;
        idle_cycle();
        @(negedge clk);
        check_value("forward_same_addr", old_val ^ 32'h0000_ffff, rd_data_o[0]);
        w[0] = reg_rec(5'd0, 32'hdead_beef);
        w[1] = reg_rec(5'd20, ~model_regs[20]);
        commit_slots(w, c);
        rd_addr_i[0] <= 5'd20;
        idle_cycle();
        @(negedge clk);
        check_value("forward_x0_target", '0, rd_data_o[2]);
        check_value("forward_after_x0", model_regs[20], rd_data_o[0]);
        idle_cycle();
        read_all_regs("forwarding_file");
    endtask

    task automatic test_flush_mem_pause();
        mem_wb_t      [ISSUE_WIDTH-1:0] w;
        commit_ctrl_t [ISSUE_WIDTH-1:0] c;
        for (int k = 0; k < 2; k++) begin
            w[0] = reg_rec(5'd3, ~model_regs[3]);
            w[1] = reg_rec(5'd4, ~model_regs[4]);
            c[0] = '{valid: 1'b1, pc: 32'h0000_4000};
            c[1] = '{valid: 1'b1, pc: 32'h0000_4004};
            drive_slots(w, c);
            if (k == 0) begin
                flush_i <= 1'b1;
            end else begin
                pause_mem_i <= 1'b1;
            end
            idle_cycle();
            flush_i     <= 1'b0;
            pause_mem_i <= 1'b0;
            idle_cycle();
            @(negedge clk);
            check_value("flush_retired", model_retired, retired_o);
            check_value("flush_last_pc", model_last_pc, last_pc_o);
        end
        read_all_regs("flush_regs");
    endtask

    task automatic test_pause_hold();
        mem_wb_t      [ISSUE_WIDTH-1:0] w;
        commit_ctrl_t [ISSUE_WIDTH-1:0] c;
        w[0] = reg_rec(5'd15, $urandom);
        w[1] = reg_rec(5'd16, $urandom);
        c[0] = '{valid: 1'b1, pc: 32'h0000_8000};
        c[1] = '{valid: 1'b1, pc: 32'h0000_8004};
        commit_slots(w, c);
        @(posedge clk);
        pause_i       <= 1'b1;
        wb_i          <= '0;
        // new commits offered during pause must not be taken
        commit_ctrl_i <= {2{commit_ctrl_t'{valid: 1'b1, pc: 32'h0000_dead}}};
        repeat (5) begin
            @(negedge clk);
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                check_value("pause_commit_o", c[s], commit_o[s]);
            end
            @(posedge clk);
        end
        pause_i       <= 1'b0;
        commit_ctrl_i <= '0;
        idle_cycle();
        @(negedge clk);
        check_value("pause_retired", model_retired, retired_o);
        check_value("pause_last_pc", model_last_pc, last_pc_o);
    endtask

    task automatic test_csr();
        mem_wb_t      [ISSUE_WIDTH-1:0] w;
        commit_ctrl_t [ISSUE_WIDTH-1:0] c;
        c = '0;
        w[0] = csr_rec(14'h2, $urandom | 32'h1);
        w[1] = csr_rec(14'h5, $urandom | 32'h1);
        commit_slots(w, c);
        csr_rd_addr_i <= 14'h2;
        idle_cycle();
        @(negedge clk);
        check_value("csr_bypass", model_csr[2], csr_rd_data_o);
        check_csr("csr_slot1_dropped", 14'h5);
        check_csr("csr_stored", 14'h2);
        // entry 4 holds a known value before the out-of-range write
        w[0] = csr_rec(14'h4, 32'h1234_5678);
        w[1] = '0;
        commit_slots(w, c);
        // upper address bits set, aliases entry 4 in the low bits
        w[0] = csr_rec(14'h104, 32'hcafe_f00d);
        commit_slots(w, c);
        idle_cycle();
        idle_cycle();
        check_csr("csr_alias", 14'h4);
        check_csr("csr_unimpl", 14'h104);
    endtask

    task automatic test_retire_pc();
        mem_wb_t      [ISSUE_WIDTH-1:0] w;
        commit_ctrl_t [ISSUE_WIDTH-1:0] c;
        w = '0;
        // back-to-back burst first
        for (int i = 0; i < 14; i++) begin
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                c[s].valid = (i < 6) ? 1'($urandom) : 1'(i >> s);
                c[s].pc    = $urandom & ~32'h3;
            end
            commit_slots(w, c);
            if (i >= 5) begin
                idle_cycle();
                idle_cycle();
                @(negedge clk);
                check_value("retire_count", model_retired, retired_o);
                check_value("retire_last_pc", model_last_pc, last_pc_o);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hc761));
        rst_n_i       = 1'b0;
        wb_i          = '0;
        commit_ctrl_i = '0;
        flush_i       = 1'b0;
        pause_i       = 1'b0;
        pause_mem_i   = 1'b0;
        rd_addr_i     = '0;
        csr_rd_addr_i = '0;
        model_regs    = '{default: '0};
        model_csr     = '{default: '0};
        model_retired = '0;
        model_last_pc = '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("reset_retired", '0, retired_o);
        check_value("reset_last_pc", '0, last_pc_o);
        read_all_regs("reset_regs");
        test_basic_commit();
        test_forwarding();
        test_flush_mem_pause();
        test_pause_hold();
        test_csr();
        test_retire_pc();
        idle_cycle();
        idle_cycle();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_props.fail_count);
        if (errors == 0 && i_dut.i_props.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/backend_pkg.sv
hw/wb_stage.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/commit_tracker.sv
hw/operand_forward.sv
hw/wb_backend_top.sv
tests/wb_backend_props.sv
tests/tb_wb_backend.sv

//--- Bender.yml
package:
  name: wb_backend

sources:
  - hw/backend_pkg.sv
  - hw/wb_stage.sv
  - hw/gpr_file.sv
  - hw/csr_file.sv
  - hw/commit_tracker.sv
  - hw/operand_forward.sv
  - hw/wb_backend_top.sv
  - target: test
    files:
      - tests/wb_backend_props.sv
      - tests/tb_wb_backend.sv
